/* all.f */
design/mem_port_pkg.sv
design/mem_map_pkg.sv
design/mem_bank.sv
design/bank_arbiter.sv
design/mem_main.sv
design/top_test.sv
tests/mem_assertions.sv
tests/mem_checker.sv
tests/tb_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top
    import mem_port_pkg::*, mem_map_pkg::*;
();

    localparam logic [31:0] run_seed = 32'h17b;
    localparam int reset_cycles = 16;
    // preload writes every bank word once, random traffic fills the rest
    localparam int num_cycles = 2000;
    localparam int preload_cycles = bank_depth;
    localparam int drain_cycles = 4;
    localparam int timeout_cycles = reset_cycles + num_cycles + 50;

    logic                    clk;
    logic                    rst_n;
    logic [host_w-1:0]       host_data;
    logic [num_rt_ports-1:0] host_we;
    logic                    host_re;
    logic [data_w-1:0]       result_data;
    logic [num_rt_ports-1:0] rt_rdy;
    logic [data_w-1:0]       mc_data;
    logic                    mc_rdy;

    int checks;
    int reset_errors;
    int rdy_errors;
    int data_errors;
    int mc_errors;
    int assert_errors;
    int total_errors;
    int cycle_cnt = 0;

    top_test dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_data   (host_data),
        .host_we     (host_we),
        .host_re     (host_re),
        .result_data (result_data),
        .rt_rdy      (rt_rdy),
        .mc_data     (mc_data),
        .mc_rdy      (mc_rdy)
    );

    mem_checker chk0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_data    (host_data),
        .host_we      (host_we),
        .host_re      (host_re),
        .result_data  (result_data),
        .rt_rdy       (rt_rdy),
        .mc_data      (mc_data),
        .mc_rdy       (mc_rdy),
        .checks       (checks),
        .reset_errors (reset_errors),
        .rdy_errors   (rdy_errors),
        .data_errors  (data_errors),
        .mc_errors    (mc_errors)
    );

    bind mem_main mem_assertions asrt0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr_rt (addr_rt),
        .addr_mc (addr_mc),
        .rdy_rt  (rdy_rt),
        .rdy_mc  (rdy_mc)
    );

    assign assert_errors = dut0.main_mem.asrt0.fail_count;

    // 4 ns period
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run still going after %0d cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // junk bits between the fields alias onto the same word
    function automatic logic [addr_w-1:0] make_addr(input int bank, input int index,
                                                    input logic junk);
        logic [addr_w-1:0] a;
        a = junk ? $urandom : '0;
        a[bank_sel_lsb +: bank_sel_w] = bank_sel_w'(bank);
        a[index_w-1:0] = index_w'(index);
        return a;
    endfunction

    // port i writes word index of bank i, no conflicts
    task automatic drive_preload(input int index);
        for (int i = 0; i < num_rt_ports; i++) begin
            host_data[i*data_w +: data_w] = {$urandom, $urandom, $urandom,
                                             make_addr(i, index, $urandom_range(0, 1) == 1)};
        end
        host_we = '1;
        host_re = $urandom_range(0, 1) == 1;
    endtask

    task automatic drive_random();
        logic spread;
        int   offset;
        int   bank;
        int   index;
        // a quarter of the words keep every port in its own bank
        spread = $urandom_range(0, 3) == 0;
        offset = $urandom_range(0, num_banks - 1);
        for (int i = 0; i < num_rt_ports; i++) begin
            if (spread) begin
                bank = (i + offset) % num_banks;
            end else begin
                bank = $urandom_range(0, num_banks - 1);
            end
            // small hot set of words for frequent repeats
            if ($urandom_range(0, 4) != 0) begin
                index = $urandom_range(0, 3);
            end else begin
                index = $urandom_range(0, bank_depth - 1);
            end
            host_data[i*data_w +: data_w] = {$urandom, $urandom, $urandom,
                                             make_addr(bank, index, $urandom_range(0, 3) == 0)};
            host_we[i] = $urandom_range(0, 2) == 0;
        end
        host_re = $urandom_range(0, 1) == 1;
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        host_data = '0;
        host_we   = '0;
        host_re   = 1'b0;
        void'($urandom(run_seed));

        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        for (int c = 0; c < num_cycles; c++) begin
            if (c < preload_cycles) begin
                drive_preload(c);
            end else begin
                drive_random();
            end
            @(negedge clk);
        end

        // idle reads while the last words leave both stages
        host_we = '0;
        host_re = 1'b0;
        repeat (drain_cycles) @(negedge clk);

        total_errors = reset_errors + rdy_errors + data_errors + mc_errors + assert_errors;
        $display("checks %0d, errors: reset %0d rdy %0d data %0d mc %0d assertions %0d",
                 checks, reset_errors, rdy_errors, data_errors, mc_errors, assert_errors);
        if (total_errors == 0 && checks > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tests/mem_checker.sv */
`timescale 1ns/1ps

module mem_checker
    import mem_port_pkg::*, mem_map_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [host_w-1:0]       host_data,
    input  logic [num_rt_ports-1:0] host_we,
    input  logic                    host_re,
    input  logic [data_w-1:0]       result_data,
    input  logic [num_rt_ports-1:0] rt_rdy,
    input  logic [data_w-1:0]       mc_data,
    input  logic                    mc_rdy,
    output int                      checks,
    output int                      reset_errors,
    output int                      rdy_errors,
    output int                      data_errors,
    output int                      mc_errors
);

    // reference memory and a flag per word set by its first write
    logic [data_w-1:0] model_mem [num_banks][bank_depth];
    logic              model_known [num_banks][bank_depth] = '{default: 1'b0};

    // history stage 0 mirrors the lane registers
    logic [num_rt_ports-1:0][addr_w-1:0] h0_addr;
    logic [num_rt_ports-1:0][data_w-1:0] h0_data;
    logic [num_rt_ports-1:0]             h0_we;
    logic                                h0_re;
    logic [addr_w-1:0]                   h0_mc_addr;

    // history stage 1 mirrors the memory return one cycle after the host
    logic [num_rt_ports-1:0]             h1_rdy;
    logic [num_rt_ports-1:0][data_w-1:0] h1_dout;
    logic [num_rt_ports-1:0]             h1_known;
    logic                                h1_conflict;
    logic                                h1_mc_rdy;
    logic [data_w-1:0]                   h1_mc_dout;
    logic                                h1_mc_known;

    // output registers two cycles after the host
    logic [num_rt_ports-1:0]             exp_rdy;
    logic [num_rt_ports-1:0][data_w-1:0] exp_dout;
    logic [num_rt_ports-1:0]             exp_known;
    logic                                exp_conflict;

    int post_edges = 0;
    int n_checks   = 0;
    int n_reset    = 0;
    int n_rdy      = 0;
    int n_data     = 0;
    int n_mc       = 0;

    assign checks       = n_checks;
    assign reset_errors = n_reset;
    assign rdy_errors   = n_rdy;
    assign data_errors  = n_data;
    assign mc_errors    = n_mc;

    // bits 21:20 pick the bank and bits 5:0 the word
    function automatic int bank_of(input logic [addr_w-1:0] addr);
        return int'(addr[bank_sel_lsb +: bank_sel_w]);
    endfunction

    function automatic int index_of(input logic [addr_w-1:0] addr);
        return int'(addr[index_w-1:0]);
    endfunction

    task automatic reset_model();
        // after lane reset port i reads bank i word 0
        for (int i = 0; i < num_rt_ports; i++) begin
            h0_addr[i] = addr_w'(i * 32'h0010_0000);
            h0_data[i] = data_w'(i);
        end
        h0_we        = '0;
        h0_re        = 1'b0;
        h0_mc_addr   = '0;
        h1_rdy       = '0;
        h1_dout      = '0;
        h1_known     = '1;
        h1_conflict  = 1'b0;
        h1_mc_rdy    = 1'b0;
        h1_mc_dout   = '0;
        h1_mc_known  = 1'b1;
        exp_rdy      = '0;
        exp_dout     = '0;
        exp_known    = '1;
        exp_conflict = 1'b0;
        post_edges   = 0;
    endtask

    task automatic step_model();
        int owner [num_banks];
        int b;
        int idx;
        // output stage takes what memory returned last cycle
        exp_rdy      = h1_rdy;
        exp_dout     = h1_dout;
        exp_known    = h1_known;
        exp_conflict = h1_conflict;

        // lowest port index owns each bank
        for (b = 0; b < num_banks; b++) begin
            owner[b] = -1;
        end
        h1_conflict = 1'b0;
        for (int i = 0; i < num_rt_ports; i++) begin
            b = bank_of(h0_addr[i]);
            if (owner[b] < 0) begin
                owner[b] = i;
            end else begin
                h1_conflict = 1'b1;
            end
        end

        // mc only on a bank no port asked for
        b = bank_of(h0_mc_addr);
        h1_mc_rdy = h0_re && owner[b] < 0;
        if (h1_mc_rdy) begin
            h1_mc_dout  = model_mem[b][index_of(h0_mc_addr)];
            h1_mc_known = model_known[b][index_of(h0_mc_addr)];
        end
        // losers keep their word
        h1_rdy = '0;
        for (int i = 0; i < num_rt_ports; i++) begin
            b   = bank_of(h0_addr[i]);
            idx = index_of(h0_addr[i]);
            if (owner[b] == i) begin
                // read first and then the write lands
                h1_rdy[i]   = 1'b1;
                h1_dout[i]  = model_mem[b][idx];
                h1_known[i] = model_known[b][idx];
                if (h0_we[i]) begin
                    model_mem[b][idx]   = h0_data[i];
                    model_known[b][idx] = 1'b1;
                end
            end
        end

        // lane registers load the new host word
        for (int i = 0; i < num_rt_ports; i++) begin
            h0_addr[i] = host_data[i*data_w +: addr_w];
            h0_data[i] = host_data[i*data_w +: data_w];
        end
        h0_we      = host_we;
        h0_re      = host_re;
        h0_mc_addr = host_data[mc_lane*data_w +: addr_w];
        post_edges = post_edges + 1;
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input logic [data_w-1:0] expected,
                                   input logic [data_w-1:0] actual);
        $display("[ERROR] %s %s at %0t ns: expected %h actual %h",
                 test, field, $time, expected, actual);
    endtask

    task automatic check_outputs();
        string test;
        logic [data_w-1:0] exp_and;
        test = exp_conflict ? "bank_conflict" : "conflict_free";
        n_checks = n_checks + 3;
        if (rt_rdy !== exp_rdy) begin
            n_rdy = n_rdy + 1;
            report_mismatch(test, "rt_rdy", data_w'(exp_rdy), data_w'(rt_rdy));
        end
        // and of the last word each port got back
        exp_and = '1;
        for (int i = 0; i < num_rt_ports; i++) begin
            exp_and = exp_and & exp_dout[i];
        end
        if (&exp_known && result_data !== exp_and) begin
            n_data = n_data + 1;
            report_mismatch("and_output", "result_data", exp_and, result_data);
        end
        if (mc_rdy !== h1_mc_rdy || (h1_mc_known && mc_data !== h1_mc_dout)) begin
            n_mc = n_mc + 1;
            report_mismatch("mc_port", "mc_rdy", data_w'(h1_mc_rdy), data_w'(mc_rdy));
            report_mismatch("mc_port", "mc_data", h1_mc_dout, mc_data);
        end
    endtask

    task automatic check_reset();
        n_checks = n_checks + 1;
        if (rt_rdy !== '0 || mc_rdy !== 1'b0 || result_data !== '0 || mc_data !== '0) begin
            n_reset = n_reset + 1;
            report_mismatch("reset_state", "rt_rdy", '0, data_w'(rt_rdy));
            report_mismatch("reset_state", "mc_rdy", '0, data_w'(mc_rdy));
            report_mismatch("reset_state", "result_data", '0, result_data);
            report_mismatch("reset_state", "mc_data", '0, mc_data);
        end
    endtask

    // model follows the DUT registers edge by edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            step_model();
        end
    end

    // outputs settle after the rising edge
    // reset state holds until the first edge after release has passed
    always @(negedge clk) begin
        if (post_edges <= 1) begin
            check_reset();
        end else begin
            check_outputs();
        end
    end

endmodule

/* tests/mem_assertions.sv */
`timescale 1ns/1ps

module mem_assertions
    import mem_port_pkg::*, mem_map_pkg::*;
(
    input logic                                clk,
    input logic                                rst_n,
    input logic [num_rt_ports-1:0][addr_w-1:0] addr_rt,
    input logic [addr_w-1:0]                   addr_mc,
    input logic [num_rt_ports-1:0]             rdy_rt,
    input logic                                rdy_mc
);

    // failures per property, summed for the testbench
    int fail_share = 0;
    int fail_mc    = 0;
    int fail_reset = 0;
    int fail_count;

    assign fail_count = fail_share + fail_mc + fail_reset;

    // two answered ports whose requests named the same bank
    function automatic logic shared_bank(
        input logic [num_rt_ports-1:0]             rdy,
        input logic [num_rt_ports-1:0][addr_w-1:0] addr
    );
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < num_rt_ports; i++) begin
            for (int j = i + 1; j < num_rt_ports; j++) begin
                if (rdy[i] && rdy[j] &&
                    addr[i][bank_sel_lsb +: bank_sel_w] == addr[j][bank_sel_lsb +: bank_sel_w]) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // mc answered from a bank that a requester also used
    function automatic logic mc_overlap(
        input logic                                mc,
        input logic [num_rt_ports-1:0]             rdy,
        input logic [addr_w-1:0]                   mc_addr,
        input logic [num_rt_ports-1:0][addr_w-1:0] addr
    );
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < num_rt_ports; i++) begin
            if (mc && rdy[i] &&
                addr[i][bank_sel_lsb +: bank_sel_w] == mc_addr[bank_sel_lsb +: bank_sel_w]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // rdy answers the requests held one cycle earlier
    a_one_per_bank: assert property (@(posedge clk) disable iff (!rst_n)
        !shared_bank(rdy_rt, $past(addr_rt)))
    else begin
        fail_share = fail_share + 1;
        $error("two requester ports answered from one bank");
    end

    a_mc_idle_bank: assert property (@(posedge clk) disable iff (!rst_n)
        !mc_overlap(rdy_mc, rdy_rt, $past(addr_mc), $past(addr_rt)))
    else begin
        fail_mc = fail_mc + 1;
        $error("mc port answered from a bank a requester used");
    end

    // nothing answers while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (rdy_rt == '0 && !rdy_mc))
    else begin
        fail_reset = fail_reset + 1;
        $error("rdy raised during reset");
    end

endmodule

/* design/top_test.sv */
`timescale 1ns/1ps

module top_test
    import mem_port_pkg::*, mem_map_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [host_w-1:0]       host_data,
    input  logic [num_rt_ports-1:0] host_we,
    input  logic                    host_re,
    output logic [data_w-1:0]       result_data,
    output logic [num_rt_ports-1:0] rt_rdy,
    output logic [data_w-1:0]       mc_data,
    output logic                    mc_rdy
);

    // host word split into lanes, lane 0 in the low bits
    logic [num_rt_ports-1:0][data_w-1:0] host_lane;

    // lane registers feeding the memory
    logic [num_rt_ports-1:0]             we_rt;
    logic [num_rt_ports-1:0][addr_w-1:0] addr_rt;
    logic [num_rt_ports-1:0][data_w-1:0] data_rt_in;
    logic                                re_mc;
    logic [addr_w-1:0]                   addr_mc;

    // memory return side
    logic [num_rt_ports-1:0][data_w-1:0] data_rt_out;
    logic [num_rt_ports-1:0]             rdy_rt;

    // output stage
    logic [num_rt_ports-1:0][data_w-1:0] out_data_q;

    assign host_lane = host_data;

    // lane registers
    // reset puts each port in its own bank at index 0, reads only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_rt_ports; i++) begin
                addr_rt[i]    <= addr_w'(i) << bank_sel_lsb;
                data_rt_in[i] <= data_w'(i);
            end
            we_rt   <= '0;
            re_mc   <= 1'b0;
            addr_mc <= '0;
        end else begin
            for (int i = 0; i < num_rt_ports; i++) begin
                addr_rt[i]    <= host_lane[i][addr_w-1:0];
                data_rt_in[i] <= host_lane[i];
            end
            we_rt   <= host_we;
            re_mc   <= host_re;
            addr_mc <= host_lane[mc_lane][addr_w-1:0];
        end
    end

    mem_main main_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .we_rt       (we_rt),
        .addr_rt     (addr_rt),
        .data_rt_in  (data_rt_in),
        .re_mc       (re_mc),
        .addr_mc     (addr_mc),
        .data_rt_out (data_rt_out),
        .rdy_rt      (rdy_rt),
        .data_mc_out (mc_data),
        .rdy_mc      (mc_rdy)
    );

    // output registers, one cycle behind the memory
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_data_q <= '0;
            rt_rdy     <= '0;
        end else begin
            out_data_q <= data_rt_out;
            rt_rdy     <= rdy_rt;
        end
    end

    // and of all four port words
    always_comb begin
        result_data = '1;
        for (int i = 0; i < num_rt_ports; i++) begin
            result_data = result_data & out_data_q[i];
        end
    end

endmodule

/* design/mem_main.sv */
`timescale 1ns/1ps

module mem_main
    import mem_port_pkg::*, mem_map_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [num_rt_ports-1:0]             we_rt,
    input  logic [num_rt_ports-1:0][addr_w-1:0] addr_rt,
    input  logic [num_rt_ports-1:0][data_w-1:0] data_rt_in,
    input  logic                                re_mc,
    input  logic [addr_w-1:0]                   addr_mc,
    output logic [num_rt_ports-1:0][data_w-1:0] data_rt_out,
    output logic [num_rt_ports-1:0]             rdy_rt,
    output logic [data_w-1:0]                   data_mc_out,
    output logic                                rdy_mc
);

    // arbiter outputs, one set per bank
    logic [num_banks-1:0]               bank_en;
    logic [num_banks-1:0]               bank_we;
    logic [num_banks-1:0][index_w-1:0]  bank_index;
    logic [num_banks-1:0][rt_idx_w-1:0] bank_owner;
    logic [num_banks-1:0]               bank_is_mc;

    // write data and read data per bank
    logic [num_banks-1:0][data_w-1:0] bank_wdata;
    logic [num_banks-1:0][data_w-1:0] bank_rdata;

    // grant tags delayed to line up with the bank read register
    logic [num_banks-1:0]               rt_grant_q;
    logic [num_banks-1:0][rt_idx_w-1:0] owner_q;
    logic [num_banks-1:0]               mc_grant_q;

    // last word returned to each port
    logic [num_rt_ports-1:0][data_w-1:0] rt_hold;
    logic [data_w-1:0]                   mc_hold;

    bank_arbiter arb (
        .addr_rt    (addr_rt),
        .we_rt      (we_rt),
        .addr_mc    (addr_mc),
        .re_mc      (re_mc),
        .bank_en    (bank_en),
        .bank_we    (bank_we),
        .bank_index (bank_index),
        .bank_owner (bank_owner),
        .bank_is_mc (bank_is_mc)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        // write data always comes from the owning port
        assign bank_wdata[b] = data_rt_in[bank_owner[b]];

        mem_bank bank (
            .clk   (clk),
            .rst_n (rst_n),
            .en    (bank_en[b]),
            .we    (bank_we[b]),
            .index (bank_index[b]),
            .wdata (bank_wdata[b]),
            .rdata (bank_rdata[b])
        );
    end

    // remember who won each bank at this edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt_grant_q <= '0;
            owner_q    <= '0;
            mc_grant_q <= '0;
        end else begin
            rt_grant_q <= bank_en & ~bank_is_mc;
            owner_q    <= bank_owner;
            mc_grant_q <= bank_is_mc;
        end
    end

    // steer bank read data back to its winner
    // losers see rdy low and keep the previous word
    always_comb begin
        rdy_rt      = '0;
        data_rt_out = rt_hold;
        rdy_mc      = 1'b0;
        data_mc_out = mc_hold;
        for (int b = 0; b < num_banks; b++) begin
            if (rt_grant_q[b]) begin
                rdy_rt[owner_q[b]]      = 1'b1;
                data_rt_out[owner_q[b]] = bank_rdata[b];
            end
            // mc wins at most one bank per cycle
            if (mc_grant_q[b]) begin
                rdy_mc      = 1'b1;
                data_mc_out = bank_rdata[b];
            end
        end
    end

    // return registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rt_hold <= '0;
            mc_hold <= '0;
        end else begin
            rt_hold <= data_rt_out;
            mc_hold <= data_mc_out;
        end
    end

endmodule

/* design/bank_arbiter.sv */
`timescale 1ns/1ps

module bank_arbiter
    import mem_port_pkg::*, mem_map_pkg::*;
(
    input  logic [num_rt_ports-1:0][addr_w-1:0] addr_rt,
    input  logic [num_rt_ports-1:0]             we_rt,
    input  logic [addr_w-1:0]                   addr_mc,
    input  logic                                re_mc,
    output logic [num_banks-1:0]                bank_en,
    output logic [num_banks-1:0]                bank_we,
    output logic [num_banks-1:0][index_w-1:0]   bank_index,
    output logic [num_banks-1:0][rt_idx_w-1:0]  bank_owner,
    output logic [num_banks-1:0]                bank_is_mc
);

    // bank field of every requester and of the mc address
    logic [bank_sel_w-1:0] rt_bank [num_rt_ports];
    logic [bank_sel_w-1:0] mc_bank;

    // some requester port aims at this bank
    logic [num_banks-1:0] rt_hit;

    // bank decode
    always_comb begin
        for (int i = 0; i < num_rt_ports; i++) begin
            rt_bank[i] = addr_rt[i][bank_sel_lsb +: bank_sel_w];
        end
        mc_bank = addr_mc[bank_sel_lsb +: bank_sel_w];
    end

    // per-bank grant
    // fixed priority, port 0 highest, mc only on an idle bank
    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            bank_en[b]    = 1'b0;
            bank_we[b]    = 1'b0;
            bank_index[b] = '0;
            bank_owner[b] = '0;
            bank_is_mc[b] = 1'b0;
            rt_hit[b]     = 1'b0;

            // walk from the top so the lowest index wins last
            for (int i = num_rt_ports - 1; i >= 0; i--) begin
                if (rt_bank[i] == bank_sel_w'(b)) begin
                    rt_hit[b]     = 1'b1;
                    bank_owner[b] = rt_idx_w'(i);
                end
            end

            if (rt_hit[b]) begin
                // requester owns the bank, read or write
                bank_en[b]    = 1'b1;
                bank_we[b]    = we_rt[bank_owner[b]];
                bank_index[b] = addr_rt[bank_owner[b]][index_w-1:0];
            end else if (re_mc && (mc_bank == bank_sel_w'(b))) begin
                // mc is read only
                bank_en[b]    = 1'b1;
                bank_is_mc[b] = 1'b1;
                bank_index[b] = addr_mc[index_w-1:0];
            end
        end
    end

endmodule

/* design/mem_bank.sv */
`timescale 1ns/1ps

module mem_bank
    import mem_port_pkg::*, mem_map_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               we,
    input  logic [index_w-1:0] index,
    input  logic [data_w-1:0]  wdata,
    output logic [data_w-1:0]  rdata
);

    // word storage, no reset on the array
    logic [data_w-1:0] mem [bank_depth];

    // write port
    // only when this bank was granted and the owner writes
    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[index] <= wdata;
        end
    end

    // registered read
    // samples the old word at the same edge the write lands (read-first)
    // holds its value on cycles without a grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (en) begin
            rdata <= mem[index];
        end
    end

endmodule

/* design/mem_map_pkg.sv */
package mem_map_pkg;

    // address map of the main memory
    // bank count, and the two address bits that pick a bank
    localparam int num_banks = 4;

    // width of the bank select field
    localparam int bank_sel_w = $clog2(num_banks);

    // bank select sits at bits 21:20
    // so the reset addresses 0x000000 .. 0x300000 land in banks 0 .. 3
    localparam int bank_sel_lsb = 20;

    // words held by one bank
    localparam int bank_depth = 64;

    // in-bank index is taken from the low address bits
    // everything between index and bank select is ignored and aliases
    localparam int index_w = $clog2(bank_depth);

endpackage

/* design/mem_port_pkg.sv */
package mem_port_pkg;

    // requester ports, one per host lane
    localparam int num_rt_ports = 4;

    // one memory word, also one host lane
    localparam int data_w = 128;

    // request address, low bits of a lane
    localparam int addr_w = 32;

    // full host word, four lanes side by side
    localparam int host_w = num_rt_ports * data_w;

    // port tag width used as bank owner
    localparam int rt_idx_w = $clog2(num_rt_ports);

    // lane that also feeds the mc read address
    localparam int mc_lane = 1;

endpackage
